// File: flight_cfg.svh
`ifndef FLIGHT_CFG_SVH
`define FLIGHT_CFG_SVH

// System clock cycles in one microsecond
`define CLKS_PER_US 2

// Receiver pulse decode
// Width that reads as stick value 0
`define RC_MIN_US 1000
// 0..1023 us span down to 0..255
`define RC_SHIFT 2
// Stick value for zero command
`define STICK_CENTER 128

// Proportional rate gain, times KP_MULT then >>> KP_SHIFT
`define KP_MULT 3
`define KP_SHIFT 2
// Symmetric clamp on axis commands
`define AXIS_LIMIT 100
// Top of the motor rate range
`define MOTOR_MAX 250

// ESC pulse framing
`define ESC_MIN_US 1000
`define ESC_US_PER_STEP 4
`define ESC_FRAME_US 2500

`endif

// File: flight_pkg.sv
package flight_pkg;

	// Decoded receiver sticks, 0..255 each
	typedef struct packed {
		logic [7:0] throttle;
		logic [7:0] yaw;
		logic [7:0] roll;
		logic [7:0] pitch;
	} stick_cmd_t;

	// One IMU sample, Euler angles and gyro rates
	typedef struct packed {
		logic signed [15:0] roll_angle;
		logic signed [15:0] pitch_angle;
		logic signed [15:0] roll_rate;
		logic signed [15:0] pitch_rate;
		logic signed [15:0] yaw_rate;
	} imu_sample_t;

	// Angle stage result
	// Gyro rates ride along so they match their own sample
	typedef struct packed {
		logic [7:0]         throttle;
		logic signed [15:0] roll_target;
		logic signed [15:0] pitch_target;
		logic signed [15:0] yaw_target;
		logic signed [15:0] roll_rate;
		logic signed [15:0] pitch_rate;
		logic signed [15:0] yaw_rate;
	} rate_target_t;

	// Body-rate commands per axis
	typedef struct packed {
		logic [7:0]        throttle;
		logic signed [8:0] roll;
		logic signed [8:0] pitch;
		logic signed [8:0] yaw;
	} axis_cmd_t;

	// Mixer output, one rate per motor
	typedef struct packed {
		logic [7:0] m1;
		logic [7:0] m2;
		logic [7:0] m3;
		logic [7:0] m4;
	} motor_rates_t;

endpackage

// File: rc_receiver.sv
`timescale 1ns/1ps
`include "flight_cfg.svh"

module rc_receiver (
	input  logic                   sys_clk,
	input  logic                   resetn,
	input  logic                   throttle_pwm,
	input  logic                   yaw_pwm,
	input  logic                   roll_pwm,
	input  logic                   pitch_pwm,
	output flight_pkg::stick_cmd_t sticks
);

	// Prescaler needs at least one bit even at 1 cycle per us
	localparam int PRE_W = (`CLKS_PER_US > 1) ? $clog2(`CLKS_PER_US) : 1;

	// Channel order 0..3 is throttle, yaw, roll, pitch
	logic [3:0] pwm_in;
	// First and second synchronizer stages
	logic [3:0] sync_a;
	logic [3:0] sync_b;
	logic [3:0][7:0] stick_val;

	assign pwm_in = {pitch_pwm, roll_pwm, yaw_pwm, throttle_pwm};

	// Clamp (width - RC_MIN_US) to 0..1023, then scale to 8 bits
	function automatic logic [7:0] to_stick(input logic [11:0] width_us);
		logic [11:0] above;
		logic [9:0]  clamped;
		if (width_us < 12'(`RC_MIN_US)) begin
			above = '0;
		end else begin
			above = width_us - 12'(`RC_MIN_US);
		end
		if (above > 12'd1023) begin
			clamped = 10'd1023;
		end else begin
			clamped = above[9:0];
		end
		return 8'(clamped >> `RC_SHIFT);
	endfunction

	// Two-flop synchronizer on all receiver inputs
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			sync_a <= '0;
			sync_b <= '0;
		end else begin
			sync_a <= pwm_in;
			sync_b <= sync_a;
		end
	end

	for (genvar ch = 0; ch < 4; ch++) begin : g_ch
		logic [PRE_W-1:0] pre;
		logic [11:0]      us_cnt;
		logic [7:0]       value;
		logic             fall;

		// Edge seen between the two synchronizer stages
		assign fall = sync_b[ch] & ~sync_a[ch];

		always_ff @(posedge sys_clk) begin
			if (!resetn) begin
				pre    <= '0;
				us_cnt <= '0;
				value  <= '0;
			end else begin
				if (sync_a[ch]) begin
					// Count whole microseconds while the pulse is high
					if (pre == PRE_W'(`CLKS_PER_US - 1)) begin
						pre <= '0;
						// Saturate on a stuck-high input
						if (us_cnt != '1) begin
							us_cnt <= us_cnt + 12'd1;
						end
					end else begin
						pre <= pre + PRE_W'(1);
					end
				end else begin
					// Idle low, so the next pulse starts from zero
					pre    <= '0;
					us_cnt <= '0;
				end
				if (fall) begin
					value <= to_stick(us_cnt);
				end
			end
		end

		assign stick_val[ch] = value;

		// Counter only grows during a pulse
		a_cnt_no_wrap: assert property (@(posedge sys_clk) disable iff (!resetn)
			sync_a[ch] |=> us_cnt >= $past(us_cnt))
			else $error("receiver channel %0d us counter wrapped", ch);
	end

	assign sticks.throttle = stick_val[0];
	assign sticks.yaw      = stick_val[1];
	assign sticks.roll     = stick_val[2];
	assign sticks.pitch    = stick_val[3];

endmodule

// File: angle_controller.sv
`timescale 1ns/1ps
`include "flight_cfg.svh"

module angle_controller (
	input  logic                     sys_clk,
	input  logic                     resetn,
	input  flight_pkg::stick_cmd_t   sticks,
	input  flight_pkg::imu_sample_t  imu,
	input  logic                     imu_valid,
	output flight_pkg::rate_target_t targets,
	output logic                     at_valid
);

	localparam logic signed [17:0] CENTER = 18'(`STICK_CENTER);

	// Centred stick commands in 18 bits for headroom
	logic signed [17:0] roll_cmd;
	logic signed [17:0] pitch_cmd;
	logic signed [17:0] yaw_cmd;
	// Commanded angle minus measured angle
	logic signed [17:0] roll_err;
	logic signed [17:0] pitch_err;

	// Clip an 18-bit result to the 16-bit target range
	function automatic logic signed [15:0] sat16(input logic signed [17:0] x);
		if (x > 18'sd32767) begin
			return 16'sh7fff;
		end else if (x < -18'sd32768) begin
			return 16'sh8000;
		end else begin
			return x[15:0];
		end
	endfunction

	assign roll_cmd  = $signed({10'd0, sticks.roll}) - CENTER;
	assign pitch_cmd = $signed({10'd0, sticks.pitch}) - CENTER;
	assign yaw_cmd   = $signed({10'd0, sticks.yaw}) - CENTER;

	assign roll_err  = roll_cmd - 18'(imu.roll_angle);
	assign pitch_err = pitch_cmd - 18'(imu.pitch_angle);

	// Strobe follows the IMU strobe by one cycle
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			at_valid <= 1'b0;
		end else begin
			at_valid <= imu_valid;
		end
	end

	// Result and gyro rates of the same sample
	always_ff @(posedge sys_clk) begin
		if (imu_valid) begin
			targets.throttle     <= sticks.throttle;
			targets.roll_target  <= sat16(roll_err);
			targets.pitch_target <= sat16(pitch_err);
			// Yaw has no angle loop so the stick is the rate target
			targets.yaw_target   <= 16'(yaw_cmd);
			targets.roll_rate    <= imu.roll_rate;
			targets.pitch_rate   <= imu.pitch_rate;
			targets.yaw_rate     <= imu.yaw_rate;
		end
	end

	a_valid_follows: assert property (@(posedge sys_clk) disable iff (!resetn)
		imu_valid |=> at_valid)
		else $error("at_valid missing one cycle after imu_valid");

endmodule

// File: rate_controller.sv
`timescale 1ns/1ps
`include "flight_cfg.svh"

module rate_controller (
	input  logic                     sys_clk,
	input  logic                     resetn,
	input  flight_pkg::rate_target_t targets,
	input  logic                     at_valid,
	output flight_pkg::axis_cmd_t    axes,
	output logic                     ax_valid
);

	localparam logic signed [20:0] KP      = 21'(`KP_MULT);
	localparam logic signed [20:0] LIM     = 21'(`AXIS_LIMIT);
	localparam logic signed [8:0]  LIM_CMD = 9'(`AXIS_LIMIT);

	logic signed [8:0] roll_cmd;
	logic signed [8:0] pitch_cmd;
	logic signed [8:0] yaw_cmd;

	// Proportional term on one axis, clamped to the axis limit
	function automatic logic signed [8:0] p_term(
		input logic signed [15:0] target,
		input logic signed [15:0] rate
	);
		logic signed [16:0] err;
		logic signed [20:0] err_x;
		logic signed [20:0] scaled;
		err    = {target[15], target} - {rate[15], rate};
		err_x  = err;
		// 21 bits holds 3 x full 17-bit error
		scaled = (err_x * KP) >>> `KP_SHIFT;
		if (scaled > LIM) begin
			return LIM_CMD;
		end else if (scaled < -LIM) begin
			return -LIM_CMD;
		end else begin
			return scaled[8:0];
		end
	endfunction

	assign roll_cmd  = p_term(targets.roll_target, targets.roll_rate);
	assign pitch_cmd = p_term(targets.pitch_target, targets.pitch_rate);
	assign yaw_cmd   = p_term(targets.yaw_target, targets.yaw_rate);

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			ax_valid <= 1'b0;
		end else begin
			ax_valid <= at_valid;
		end
	end

	// Overwritten on every angle stage result
	always_ff @(posedge sys_clk) begin
		if (at_valid) begin
			axes.throttle <= targets.throttle;
			axes.roll     <= roll_cmd;
			axes.pitch    <= pitch_cmd;
			axes.yaw      <= yaw_cmd;
		end
	end

	// Mixer headroom relies on this bound
	a_axis_limit: assert property (@(posedge sys_clk) disable iff (!resetn)
		ax_valid |-> (axes.roll <= LIM_CMD && axes.roll >= -LIM_CMD &&
			axes.pitch <= LIM_CMD && axes.pitch >= -LIM_CMD &&
			axes.yaw <= LIM_CMD && axes.yaw >= -LIM_CMD))
		else $error("axis command beyond AXIS_LIMIT");

endmodule

// File: motor_mixer.sv
`timescale 1ns/1ps
`include "flight_cfg.svh"

module motor_mixer (
	input  logic                     sys_clk,
	input  logic                     resetn,
	input  flight_pkg::axis_cmd_t    axes,
	input  logic                     ax_valid,
	output flight_pkg::motor_rates_t motors,
	output logic                     mix_valid
);

	localparam logic signed [11:0] MAX_S = 12'(`MOTOR_MAX);

	// Sign-extended operands, 12 bits fit throttle plus three axes
	logic signed [11:0] thr;
	logic signed [11:0] roll;
	logic signed [11:0] pitch;
	logic signed [11:0] yaw;

	// Floor at 0, ceiling at MOTOR_MAX
	function automatic logic [7:0] clamp_motor(input logic signed [11:0] sum);
		if (sum < 12'sd0) begin
			return 8'd0;
		end else if (sum > MAX_S) begin
			return 8'(`MOTOR_MAX);
		end else begin
			return sum[7:0];
		end
	endfunction

	assign thr   = $signed({4'd0, axes.throttle});
	assign roll  = 12'(axes.roll);
	assign pitch = 12'(axes.pitch);
	assign yaw   = 12'(axes.yaw);

	// Quad-X layout, props alternate spin direction for yaw
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			mix_valid <= 1'b0;
			motors    <= '0;
		end else begin
			mix_valid <= ax_valid;
			if (ax_valid) begin
				motors.m1 <= clamp_motor(thr + pitch + roll - yaw);
				motors.m2 <= clamp_motor(thr + pitch - roll + yaw);
				motors.m3 <= clamp_motor(thr - pitch - roll - yaw);
				motors.m4 <= clamp_motor(thr - pitch + roll + yaw);
			end
		end
	end

	// ESC pulse must stay inside its frame
	a_motor_max: assert property (@(posedge sys_clk) disable iff (!resetn)
		motors.m1 <= 8'(`MOTOR_MAX) && motors.m2 <= 8'(`MOTOR_MAX) &&
		motors.m3 <= 8'(`MOTOR_MAX) && motors.m4 <= 8'(`MOTOR_MAX))
		else $error("motor rate above MOTOR_MAX");

endmodule

// File: esc_pwm.sv
`timescale 1ns/1ps
`include "flight_cfg.svh"

module esc_pwm (
	input  logic                     sys_clk,
	input  logic                     resetn,
	input  flight_pkg::motor_rates_t motors,
	output logic                     motor_1_pwm,
	output logic                     motor_2_pwm,
	output logic                     motor_3_pwm,
	output logic                     motor_4_pwm
);

	localparam int PRE_W = (`CLKS_PER_US > 1) ? $clog2(`CLKS_PER_US) : 1;

	// Microsecond prescaler and position within the frame
	logic [PRE_W-1:0] pre;
	logic [11:0]      frame_us;
	logic             frame_start;
	// Index 0..3 is motor 1..4
	logic [3:0][7:0]  rate_in;
	logic [3:0][7:0]  rate_q;
	logic [3:0][7:0]  rate_sel;
	logic [3:0][11:0] width_us;
	logic [3:0]       pwm_q;

	assign frame_start = (pre == '0) && (frame_us == '0);
	assign rate_in     = {motors.m4, motors.m3, motors.m2, motors.m1};

	// Frame counter runs from the first cycle after reset
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			pre      <= '0;
			frame_us <= '0;
		end else if (pre == PRE_W'(`CLKS_PER_US - 1)) begin
			pre <= '0;
			if (frame_us == 12'(`ESC_FRAME_US - 1)) begin
				frame_us <= '0;
			end else begin
				frame_us <= frame_us + 12'd1;
			end
		end else begin
			pre <= pre + PRE_W'(1);
		end
	end

	// Rates held for the whole frame
	always_ff @(posedge sys_clk) begin
		if (frame_start) begin
			rate_q <= rate_in;
		end
	end

	// At frame start the latch is not loaded yet, take the live rates
	assign rate_sel = frame_start ? rate_in : rate_q;

	always_comb begin
		for (int ch = 0; ch < 4; ch++) begin
			width_us[ch] = 12'(`ESC_MIN_US) + 12'(`ESC_US_PER_STEP) * 12'(rate_sel[ch]);
		end
	end

	// Registered compare, pulse covers width_us whole microseconds
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			pwm_q <= '0;
		end else begin
			for (int ch = 0; ch < 4; ch++) begin
				pwm_q[ch] <= frame_us < width_us[ch];
			end
		end
	end

	assign motor_1_pwm = pwm_q[0];
	assign motor_2_pwm = pwm_q[1];
	assign motor_3_pwm = pwm_q[2];
	assign motor_4_pwm = pwm_q[3];

endmodule

// File: flight_ctrl_top.sv
`timescale 1ns/1ps

module flight_ctrl_top (
	input  logic                     sys_clk,
	input  logic                     resetn,
	input  logic                     throttle_pwm,
	input  logic                     yaw_pwm,
	input  logic                     roll_pwm,
	input  logic                     pitch_pwm,
	input  flight_pkg::imu_sample_t  imu,
	input  logic                     imu_valid,
	output logic                     motor_1_pwm,
	output logic                     motor_2_pwm,
	output logic                     motor_3_pwm,
	output logic                     motor_4_pwm,
	output flight_pkg::stick_cmd_t   sticks,
	output flight_pkg::motor_rates_t motors,
	output logic                     mix_valid
);

	// Pipeline links between the three stages
	flight_pkg::rate_target_t targets;
	logic                     at_valid;
	flight_pkg::axis_cmd_t    axes;
	logic                     ax_valid;

	// Stick levels, updated at each receiver pulse end
	rc_receiver u_rc_receiver (
		.sys_clk(sys_clk), .resetn(resetn),
		.throttle_pwm(throttle_pwm), .yaw_pwm(yaw_pwm),
		.roll_pwm(roll_pwm), .pitch_pwm(pitch_pwm),
		.sticks(sticks)
	);

	// Stage 1, sampled on the IMU strobe
	angle_controller u_angle_controller (
		.sys_clk(sys_clk), .resetn(resetn),
		.sticks(sticks), .imu(imu), .imu_valid(imu_valid),
		.targets(targets), .at_valid(at_valid)
	);

	// Stage 2
	rate_controller u_rate_controller (
		.sys_clk(sys_clk), .resetn(resetn),
		.targets(targets), .at_valid(at_valid),
		.axes(axes), .ax_valid(ax_valid)
	);

	// Stage 3, motors valid 3 cycles after imu_valid
	motor_mixer u_motor_mixer (
		.sys_clk(sys_clk), .resetn(resetn),
		.axes(axes), .ax_valid(ax_valid),
		.motors(motors), .mix_valid(mix_valid)
	);

	// Samples the motor rates once per frame
	esc_pwm u_esc_pwm (
		.sys_clk(sys_clk), .resetn(resetn),
		.motors(motors),
		.motor_1_pwm(motor_1_pwm), .motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm), .motor_4_pwm(motor_4_pwm)
	);

endmodule

// File: tb_flight_ctrl.sv
`timescale 1ns/1ps
`include "flight_cfg.svh"

module tb_flight_ctrl;

	localparam int FRAME_CYC   = `ESC_FRAME_US * `CLKS_PER_US;
	// Longest receiver round, then the decode delay and idle gap
	localparam int ROUND_CYC   = 2100 * `CLKS_PER_US + 2 + 6;
	localparam int RX_ROUNDS   = 23;
	// Alignment can cost up to two frames before two measured ones
	localparam int RUN_CYC     = 8 + RX_ROUNDS * ROUND_CYC + 2 * 100 + 4 * FRAME_CYC;
	localparam int CYCLE_LIMIT = RUN_CYC + RUN_CYC / 5;

	logic                     sys_clk;
	logic                     resetn;
	logic [3:0]               rc_pins;
	flight_pkg::imu_sample_t  imu;
	logic                     imu_valid;
	logic [3:0]               esc_pins;
	flight_pkg::stick_cmd_t   sticks;
	flight_pkg::motor_rates_t motors;
	logic                     mix_valid;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int test_start;
	// Expected sticks in channel order throttle, yaw, roll, pitch
	int exp_stick[4];
	int widths[4];
	int hit_floor;
	int hit_ceiling;
	flight_pkg::motor_rates_t esc_rates;
	// In-flight model results as {valid, motors}
	logic [32:0] pend[$];

	flight_ctrl_top u_dut (
		.sys_clk(sys_clk), .resetn(resetn),
		.throttle_pwm(rc_pins[0]), .yaw_pwm(rc_pins[1]),
		.roll_pwm(rc_pins[2]), .pitch_pwm(rc_pins[3]),
		.imu(imu), .imu_valid(imu_valid),
		.motor_1_pwm(esc_pins[0]), .motor_2_pwm(esc_pins[1]),
		.motor_3_pwm(esc_pins[2]), .motor_4_pwm(esc_pins[3]),
		.sticks(sticks), .motors(motors), .mix_valid(mix_valid)
	);

	initial begin
		sys_clk = 1'b0;
	end

	always #20 sys_clk = ~sys_clk;

	// Run limit
	always @(posedge sys_clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run stopped: cycle limit %0d reached before the tests ended", CYCLE_LIMIT);
			$display("tests failed");
			$finish;
		end
	end

	task automatic compare_value(input int got, input int exp, input string what);
		checks++;
		assert (got == exp) else begin
			$display("Error %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic next_slot();
		@(posedge sys_clk);
		#2;
	endtask

	task automatic report_test(input string name);
		$display("test %-10s %s, %0d errors", name,
			(errors == test_start) ? "ok" : "FAILED", errors - test_start);
		test_start = errors;
	endtask

	// Receiver rule from width in us to 0..255
	function automatic int stick_from_width(input int w);
		int above;
		above = (w < `RC_MIN_US) ? 0 : w - `RC_MIN_US;
		if (above > 1023) begin
			above = 1023;
		end
		return above >> `RC_SHIFT;
	endfunction

	function automatic int stick_field(input int ch);
		case (ch)
			0: return int'(sticks.throttle);
			1: return int'(sticks.yaw);
			2: return int'(sticks.roll);
			default: return int'(sticks.pitch);
		endcase
	endfunction

	function automatic int clip(input int x, input int lo, input int hi);
		if (x < lo) begin
			return lo;
		end
		return (x > hi) ? hi : x;
	endfunction

	// P term on one axis
	function automatic int axis_cmd(input int target, input int rate);
		int scaled;
		scaled = ((target - rate) * `KP_MULT) >>> `KP_SHIFT;
		return clip(scaled, -`AXIS_LIMIT, `AXIS_LIMIT);
	endfunction

	// Angle stage, rate stage and quad-X mix on one sample
	function automatic flight_pkg::motor_rates_t model_mix(input flight_pkg::imu_sample_t s);
		flight_pkg::motor_rates_t m;
		int thr;
		int r;
		int p;
		int y;
		thr = exp_stick[0];
		r = clip(exp_stick[2] - `STICK_CENTER - int'(s.roll_angle), -32768, 32767);
		p = clip(exp_stick[3] - `STICK_CENTER - int'(s.pitch_angle), -32768, 32767);
		y = exp_stick[1] - `STICK_CENTER;
		r = axis_cmd(r, int'(s.roll_rate));
		p = axis_cmd(p, int'(s.pitch_rate));
		y = axis_cmd(y, int'(s.yaw_rate));
		m.m1 = 8'(clip(thr + p + r - y, 0, `MOTOR_MAX));
		m.m2 = 8'(clip(thr + p - r + y, 0, `MOTOR_MAX));
		m.m3 = 8'(clip(thr - p - r - y, 0, `MOTOR_MAX));
		m.m4 = 8'(clip(thr - p + r + y, 0, `MOTOR_MAX));
		return m;
	endfunction

	function automatic flight_pkg::imu_sample_t random_imu(input int span);
		flight_pkg::imu_sample_t s;
		s.roll_angle  = 16'(int'($urandom % (2 * span + 1)) - span);
		s.pitch_angle = 16'(int'($urandom % (2 * span + 1)) - span);
		s.roll_rate   = 16'(int'($urandom % (2 * span + 1)) - span);
		s.pitch_rate  = 16'(int'($urandom % (2 * span + 1)) - span);
		s.yaw_rate    = 16'(int'($urandom % (2 * span + 1)) - span);
		return s;
	endfunction

	function automatic logic [15:0] extreme_word();
		case ($urandom % 4)
			0: return 16'h8000;
			1: return 16'h7fff;
			2: return 16'hb1e0;
			default: return 16'h4e20;
		endcase
	endfunction

	// One pulse per channel with all rising together
	task automatic rx_round();
		int last;
		last = 0;
		for (int ch = 0; ch < 4; ch++) begin
			if (widths[ch] > last) begin
				last = widths[ch];
			end
		end
		rc_pins = 4'hf;
		for (int c = 1; c <= last * `CLKS_PER_US + 2; c++) begin
			next_slot();
			for (int ch = 0; ch < 4; ch++) begin
				if (c == widths[ch] * `CLKS_PER_US) begin
					rc_pins[ch] = 1'b0;
				end
				// Two edges after the fall the value is settled
				if (c == widths[ch] * `CLKS_PER_US + 2) begin
					exp_stick[ch] = stick_from_width(widths[ch]);
					compare_value(stick_field(ch), exp_stick[ch], $sformatf("stick %0d", ch));
				end
			end
		end
		repeat (6) next_slot();
	endtask

	// Check the result due now, then drive this cycle's sample
	task automatic pipe_step(input logic valid, input flight_pkg::imu_sample_t s);
		logic [32:0] head;
		if (pend.size() == 3) begin
			head = pend.pop_front();
			compare_value(int'(mix_valid), int'(head[32]), "mix_valid");
			if (head[32]) begin
				compare_value(int'(motors), int'(head[31:0]), "motors");
				if (motors.m1 == 0 || motors.m2 == 0 || motors.m3 == 0 || motors.m4 == 0) begin
					hit_floor++;
				end
				if (motors.m1 == `MOTOR_MAX || motors.m2 == `MOTOR_MAX ||
					motors.m3 == `MOTOR_MAX || motors.m4 == `MOTOR_MAX) begin
					hit_ceiling++;
				end
			end
		end
		imu = s;
		imu_valid = valid;
		pend.push_back({valid, valid ? model_mix(s) : 32'd0});
		next_slot();
	endtask

	task automatic pipe_drain();
		repeat (3) pipe_step(1'b0, '0);
		pend.delete();
	endtask

	task automatic align_to_frame();
		while (esc_pins[0]) begin
			next_slot();
		end
		while (!esc_pins[0]) begin
			next_slot();
		end
	endtask

	// Starts on the first high slot of a frame, ends on the next one
	task automatic measure_frame(input flight_pkg::motor_rates_t r);
		int hi[4];
		int len;
		logic prev_m1;
		logic [3:0][7:0] rate;
		rate = {r.m4, r.m3, r.m2, r.m1};
		hi = '{default: 0};
		len = 0;
		do begin
			for (int ch = 0; ch < 4; ch++) begin
				hi[ch] += esc_pins[ch] ? 1 : 0;
			end
			len++;
			prev_m1 = esc_pins[0];
			next_slot();
		end while (!(esc_pins[0] && !prev_m1));
		compare_value(len, FRAME_CYC, "ESC frame period");
		for (int ch = 0; ch < 4; ch++) begin
			compare_value(hi[ch], (`ESC_MIN_US + `ESC_US_PER_STEP * int'(rate[ch])) *
				`CLKS_PER_US, $sformatf("motor %0d pulse", ch + 1));
		end
	endtask

	initial begin
		flight_pkg::imu_sample_t s;
		void'($urandom(32'h797e));
		resetn = 1'b0;
		rc_pins = 4'h0;
		imu = '0;
		imu_valid = 1'b0;
		test_start = 0;
		hit_floor = 0;
		hit_ceiling = 0;
		exp_stick = '{default: 0};

		// Reset state held through and after reset
		repeat (4) begin
			next_slot();
			compare_value(int'(esc_pins), 0, "ESC pins in reset");
			compare_value(int'(mix_valid), 0, "mix_valid in reset");
			compare_value(int'(motors), 0, "motors in reset");
			compare_value(int'(sticks), 0, "sticks in reset");
		end
		resetn = 1'b1;
		repeat (3) begin
			next_slot();
			compare_value(int'(mix_valid), 0, "mix_valid after reset");
			compare_value(int'(motors), 0, "motors after reset");
			compare_value(int'(sticks), 0, "sticks after reset");
		end
		report_test("reset");

		// Random widths on every channel
		repeat (20) begin
			for (int ch = 0; ch < 4; ch++) begin
				widths[ch] = 900 + int'($urandom % 1201);
			end
			rx_round();
		end
		report_test("receiver");

		// Mix of back-to-back and gapped samples
		for (int i = 0; i < 40; i++) begin
			pipe_step(($urandom % 3) != 0, random_imu(80));
		end
		pipe_drain();
		report_test("pipeline");

		// Full-scale sticks with extreme samples at high then low throttle
		for (int pass = 0; pass < 2; pass++) begin
			if (pass == 0) begin
				widths = '{2100, 2100, 2100, 2100};
			end else begin
				widths = '{900, 900, 900, 900};
			end
			rx_round();
			for (int i = 0; i < 24; i++) begin
				s = {extreme_word(), extreme_word(), extreme_word(), extreme_word(),
					extreme_word()};
				pipe_step(1'b1, s);
			end
			pipe_drain();
		end
		checks++;
		assert (hit_floor > 0 && hit_ceiling > 0) else begin
			$display("Saturation stimulus never drove a motor to both 0 and MOTOR_MAX");
			errors++;
		end
		report_test("saturation");

		// Known rates then two measured frames
		widths = '{1400 + int'($urandom % 300), 1450, 1520, 1480};
		rx_round();
		s = random_imu(40);
		esc_rates = model_mix(s);
		pipe_step(1'b1, s);
		pipe_drain();
		align_to_frame();
		measure_frame(esc_rates);
		measure_frame(esc_rates);
		report_test("esc");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+.
flight_pkg.sv
rc_receiver.sv
angle_controller.sv
rate_controller.sv
motor_mixer.sv
esc_pwm.sv
flight_ctrl_top.sv
tb_flight_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_flight_ctrl
FILELIST  := sources.f
OBJ_DIR   := obj_dir

SRCS := $(shell grep -v '^+' $(FILELIST)) flight_cfg.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ_DIR)
